// File: design/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath and instruction width
`define CORE_XLEN          32
`define CORE_REG_COUNT     32

// instruction field positions
`define CORE_OP_MSB        31
`define CORE_OP_LSB        27
`define CORE_RD_MSB        26
`define CORE_RD_LSB        22
`define CORE_RS_MSB        21
`define CORE_RS_LSB        17
`define CORE_RT_MSB        16
`define CORE_RT_LSB        12
`define CORE_SHAMT_MSB     11
`define CORE_SHAMT_LSB     7
`define CORE_ALUOP_MSB     6
`define CORE_ALUOP_LSB     2

`define CORE_IMM_WIDTH     17   // I-type immediate, sign-extended
`define CORE_TARGET_WIDTH  27   // J-type target, zero-extended

`define CORE_LINK_REG      5'd31  // jal destination

`endif

// File: design/core_pkg.sv
`include "core_defines.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [$clog2(`CORE_REG_COUNT)-1:0] reg_idx_t;

    // major opcodes, anything else runs as a nop
    typedef enum logic [4:0] {
        OP_ALU  = 5'b00000,
        OP_J    = 5'b00001,
        OP_BNE  = 5'b00010,
        OP_JAL  = 5'b00011,
        OP_JR   = 5'b00100,
        OP_ADDI = 5'b00101,
        OP_BLT  = 5'b00110,
        OP_SW   = 5'b00111,
        OP_LW   = 5'b01000
    } opcode_e;

    // R-type function field
    typedef enum logic [4:0] {
        ALU_ADD = 5'd0,
        ALU_SUB = 5'd1,
        ALU_AND = 5'd2,
        ALU_OR  = 5'd3,
        ALU_SLL = 5'd4,
        ALU_SRA = 5'd5
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG,    // value read in decode
        FWD_MEM,    // execute/memory register
        FWD_WB      // memory/writeback register
    } fwd_sel_e;

endpackage

// File: design/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import core_pkg::*; (
    input  logic  clock,
    input  logic  rst_n_i,
    input  logic  stall_i,
    input  logic  redirect_i,
    input  word_t redirect_target_i,
    input  word_t imem_data_i,
    output word_t imem_addr_o,
    output word_t fd_ir_o,
    output word_t fd_pc_o
);

    word_t pc;
    word_t pc_plus1;

    assign pc_plus1    = pc + 1'b1;
    assign imem_addr_o = pc;   // word address, data returns same cycle

    // redirect wins over a load-use stall
    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc      <= '0;
            fd_ir_o <= '0;
        end else if (redirect_i) begin
            pc      <= redirect_target_i;
            fd_ir_o <= '0;   // squash wrong-path fetch
        end else if (!stall_i) begin
            pc      <= pc_plus1;
            fd_ir_o <= imem_data_i;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall_i) begin
            fd_pc_o <= pc_plus1;   // travels with the instruction
        end
    end

endmodule

// File: design/register_file.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module register_file import core_pkg::*; (
    input  logic     clock,
    input  logic     rst_n_i,
    input  reg_idx_t rd_idx_a_i,
    input  reg_idx_t rd_idx_b_i,
    input  reg_idx_t wr_idx_i,
    input  word_t    wr_data_i,
    input  logic     wr_en_i,
    output word_t    rd_data_a_o,
    output word_t    rd_data_b_o
);

    word_t regs [0:`CORE_REG_COUNT-1];
    logic  wr_ok;

    assign wr_ok = wr_en_i && (wr_idx_i != '0);   // r0 stays zero

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wr_idx_i] <= wr_data_i;
        end
    end

    // same-cycle write shows up on the read ports
    assign rd_data_a_o = (rd_idx_a_i == '0) ? '0 :
                         (wr_ok && wr_idx_i == rd_idx_a_i) ? wr_data_i :
                         regs[rd_idx_a_i];

    assign rd_data_b_o = (rd_idx_b_i == '0) ? '0 :
                         (wr_ok && wr_idx_i == rd_idx_b_i) ? wr_data_i :
                         regs[rd_idx_b_i];

endmodule

// File: design/decode_stage.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module decode_stage import core_pkg::*; (
    input  logic     clock,
    input  logic     rst_n_i,
    input  word_t    fd_ir_i,
    input  word_t    fd_pc_i,
    input  word_t    rd_data_a_i,
    input  word_t    rd_data_b_i,
    input  logic     flush_i,
    output reg_idx_t rd_idx_a_o,
    output reg_idx_t rd_idx_b_o,
    output logic     stall_o,
    output word_t    dx_ir_o,
    output word_t    dx_pc_o,
    output word_t    dx_a_o,
    output word_t    dx_b_o
);

    opcode_e  opcode;
    opcode_e  dx_opcode;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    reg_idx_t dx_rd;
    logic     uses_a;
    logic     uses_b;
    logic     hazard_a;
    logic     hazard_b;
    word_t    ir_next;

    assign opcode = opcode_e'(fd_ir_i[`CORE_OP_MSB:`CORE_OP_LSB]);
    assign rs     = fd_ir_i[`CORE_RS_MSB:`CORE_RS_LSB];
    assign rt     = fd_ir_i[`CORE_RT_MSB:`CORE_RT_LSB];
    assign rd     = fd_ir_i[`CORE_RD_MSB:`CORE_RD_LSB];

    // second port reads rt for R-type, rd for branches, jr and sw
    assign rd_idx_a_o = rs;
    assign rd_idx_b_o = (opcode == OP_ALU) ? rt : rd;

    // which ports actually feed the datapath
    assign uses_a = opcode inside {OP_ALU, OP_ADDI, OP_BNE, OP_BLT, OP_SW, OP_LW};
    assign uses_b = opcode inside {OP_ALU, OP_BNE, OP_BLT, OP_JR};   // sw data fixed up later

    assign dx_opcode = opcode_e'(dx_ir_o[`CORE_OP_MSB:`CORE_OP_LSB]);
    assign dx_rd     = dx_ir_o[`CORE_RD_MSB:`CORE_RD_LSB];

    assign hazard_a = uses_a && (rd_idx_a_o != '0) && (rd_idx_a_o == dx_rd);
    assign hazard_b = uses_b && (rd_idx_b_o != '0) && (rd_idx_b_o == dx_rd);

    // load result is not ready until writeback, hold one cycle
    assign stall_o = (dx_opcode == OP_LW) && (hazard_a || hazard_b);

    assign ir_next = (stall_o || flush_i) ? '0 : fd_ir_i;   // bubble = add r0,r0,r0

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dx_ir_o <= '0;
        end else begin
            dx_ir_o <= ir_next;
        end
    end

    always_ff @(posedge clock) begin
        dx_pc_o <= fd_pc_i;
        dx_a_o  <= rd_data_a_i;
        dx_b_o  <= rd_data_b_i;
    end

endmodule

// File: design/execute_stage.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module execute_stage import core_pkg::*; (
    input  logic     clock,
    input  logic     rst_n_i,
    input  word_t    dx_ir_i,
    input  word_t    dx_pc_i,          // pc-plus-one
    input  word_t    dx_a_i,
    input  word_t    dx_b_i,
    input  reg_idx_t wb_idx_i,
    input  word_t    wb_data_i,
    input  logic     wb_en_i,
    output logic     redirect_o,
    output word_t    redirect_target_o,
    output word_t    xm_ir_o,
    output word_t    xm_result_o,
    output word_t    xm_b_o
);

    opcode_e  opcode;
    opcode_e  xm_opcode;
    alu_op_e  alu_fn;
    reg_idx_t src_a;
    reg_idx_t src_b;
    reg_idx_t xm_dest;
    logic     xm_writes;
    fwd_sel_e sel_a;
    fwd_sel_e sel_b;
    word_t    op_a;
    word_t    op_b;
    word_t    imm;
    word_t    target;
    word_t    alu_b;
    word_t    alu_out;
    word_t    result;
    logic [`CORE_SHAMT_MSB-`CORE_SHAMT_LSB:0] shamt;

    // nearest producer wins
    function automatic fwd_sel_e fwd_pick(
        input reg_idx_t idx,
        input logic     mem_en,
        input reg_idx_t mem_idx,
        input logic     wb_en,
        input reg_idx_t wb_idx
    );
        fwd_sel_e sel;
        sel = FWD_REG;
        if (idx != '0 && wb_en && idx == wb_idx) begin
            sel = FWD_WB;
        end
        if (idx != '0 && mem_en && idx == mem_idx) begin
            sel = FWD_MEM;
        end
        return sel;
    endfunction

    assign opcode = opcode_e'(dx_ir_i[`CORE_OP_MSB:`CORE_OP_LSB]);
    assign src_a  = dx_ir_i[`CORE_RS_MSB:`CORE_RS_LSB];
    assign src_b  = (opcode == OP_ALU) ? dx_ir_i[`CORE_RT_MSB:`CORE_RT_LSB]
                                       : dx_ir_i[`CORE_RD_MSB:`CORE_RD_LSB];

    // lw result not ready here, decode stalls for it
    assign xm_opcode = opcode_e'(xm_ir_o[`CORE_OP_MSB:`CORE_OP_LSB]);
    assign xm_writes = xm_opcode inside {OP_ALU, OP_ADDI, OP_JAL};
    assign xm_dest   = (xm_opcode == OP_JAL) ? `CORE_LINK_REG
                                             : xm_ir_o[`CORE_RD_MSB:`CORE_RD_LSB];

    assign sel_a = fwd_pick(src_a, xm_writes, xm_dest, wb_en_i, wb_idx_i);
    assign sel_b = fwd_pick(src_b, xm_writes, xm_dest, wb_en_i, wb_idx_i);

    always_comb begin
        case (sel_a)
            FWD_MEM: op_a = xm_result_o;
            FWD_WB:  op_a = wb_data_i;
            default: op_a = dx_a_i;
        endcase
        case (sel_b)
            FWD_MEM: op_b = xm_result_o;
            FWD_WB:  op_b = wb_data_i;
            default: op_b = dx_b_i;
        endcase
    end

    assign imm = {{(`CORE_XLEN-`CORE_IMM_WIDTH){dx_ir_i[`CORE_IMM_WIDTH-1]}},
                  dx_ir_i[`CORE_IMM_WIDTH-1:0]};
    assign target = {{(`CORE_XLEN-`CORE_TARGET_WIDTH){1'b0}},
                     dx_ir_i[`CORE_TARGET_WIDTH-1:0]};

    assign alu_b  = (opcode inside {OP_ADDI, OP_LW, OP_SW}) ? imm : op_b;
    assign alu_fn = (opcode == OP_ALU) ? alu_op_e'(dx_ir_i[`CORE_ALUOP_MSB:`CORE_ALUOP_LSB])
                                       : ALU_ADD;   // addr calc for lw/sw
    assign shamt  = dx_ir_i[`CORE_SHAMT_MSB:`CORE_SHAMT_LSB];

    always_comb begin
        case (alu_fn)
            ALU_ADD: alu_out = op_a + alu_b;
            ALU_SUB: alu_out = op_a - alu_b;
            ALU_AND: alu_out = op_a & alu_b;
            ALU_OR:  alu_out = op_a | alu_b;
            ALU_SLL: alu_out = op_a << shamt;
            ALU_SRA: alu_out = $signed(op_a) >>> shamt;
            default: alu_out = '0;
        endcase
    end

    assign result = (opcode == OP_JAL) ? dx_pc_i : alu_out;   // link value

    // rd sits on port b, so blt compares b against a
    always_comb begin
        case (opcode)
            OP_J, OP_JAL: redirect_o = 1'b1;
            OP_JR:        redirect_o = 1'b1;
            OP_BNE:       redirect_o = (op_b != op_a);
            OP_BLT:       redirect_o = ($signed(op_b) < $signed(op_a));
            default:      redirect_o = 1'b0;
        endcase
    end

    assign redirect_target_o = (opcode inside {OP_BNE, OP_BLT}) ? dx_pc_i + imm :
                               (opcode == OP_JR) ? op_b : target;

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            xm_ir_o <= '0;
        end else begin
            xm_ir_o <= dx_ir_i;
        end
    end

    always_ff @(posedge clock) begin
        xm_result_o <= result;
        xm_b_o      <= op_b;   // store data, may still be stale after lw
    end

endmodule

// File: design/memory_stage.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module memory_stage import core_pkg::*; (
    input  logic     clock,
    input  logic     rst_n_i,
    input  word_t    xm_ir_i,
    input  word_t    xm_result_i,
    input  word_t    xm_b_i,
    input  word_t    dmem_rdata_i,
    output word_t    dmem_addr_o,
    output word_t    dmem_wdata_o,
    output logic     dmem_wren_o,
    output reg_idx_t wb_idx_o,
    output word_t    wb_data_o,
    output logic     wb_en_o
);

    opcode_e  opcode;
    reg_idx_t rd;
    reg_idx_t dest;
    logic     writes;
    logic     is_load;
    logic     st_fwd;
    word_t    wb_value;

    assign opcode  = opcode_e'(xm_ir_i[`CORE_OP_MSB:`CORE_OP_LSB]);
    assign rd      = xm_ir_i[`CORE_RD_MSB:`CORE_RD_LSB];
    assign is_load = (opcode == OP_LW);

    assign dmem_addr_o = xm_result_i;   // rs + imm
    assign dmem_wren_o = (opcode == OP_SW);

    // lw right before sw hands its data over here
    assign st_fwd       = wb_en_o && (wb_idx_o == rd);
    assign dmem_wdata_o = st_fwd ? wb_data_o : xm_b_i;

    assign writes   = opcode inside {OP_ALU, OP_ADDI, OP_LW, OP_JAL};
    assign dest     = (opcode == OP_JAL) ? `CORE_LINK_REG : rd;
    assign wb_value = is_load ? dmem_rdata_i : xm_result_i;

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_en_o <= 1'b0;
        end else begin
            wb_en_o <= writes && (dest != '0);   // r0 writes dropped
        end
    end

    always_ff @(posedge clock) begin
        wb_idx_o  <= dest;
        wb_data_o <= wb_value;
    end

endmodule

// File: design/pipeline_core.sv
`timescale 1ns/1ps

module pipeline_core import core_pkg::*; (
    input  logic  clock,
    input  logic  rst_n_i,
    input  word_t imem_data_i,
    input  word_t dmem_rdata_i,
    output word_t imem_addr_o,
    output word_t dmem_addr_o,
    output word_t dmem_wdata_o,
    output logic  dmem_wren_o
);

    // fetch -> decode
    word_t    fd_ir;
    word_t    fd_pc;
    logic     stall;

    // decode <-> register file
    reg_idx_t rd_idx_a;
    reg_idx_t rd_idx_b;
    word_t    rd_data_a;
    word_t    rd_data_b;

    // decode -> execute
    word_t    dx_ir;
    word_t    dx_pc;
    word_t    dx_a;
    word_t    dx_b;

    // execute -> fetch/decode, execute -> memory
    logic     redirect;
    word_t    redirect_target;
    word_t    xm_ir;
    word_t    xm_result;
    word_t    xm_b;

    // writeback port, also a forwarding source
    reg_idx_t wb_idx;
    word_t    wb_data;
    logic     wb_en;

    fetch_stage u_fetch (
        .clock             (clock),
        .rst_n_i           (rst_n_i),
        .stall_i           (stall),
        .redirect_i        (redirect),
        .redirect_target_i (redirect_target),
        .imem_data_i       (imem_data_i),
        .imem_addr_o       (imem_addr_o),
        .fd_ir_o           (fd_ir),
        .fd_pc_o           (fd_pc)
    );

    decode_stage u_decode (
        .clock       (clock),
        .rst_n_i     (rst_n_i),
        .fd_ir_i     (fd_ir),
        .fd_pc_i     (fd_pc),
        .rd_data_a_i (rd_data_a),
        .rd_data_b_i (rd_data_b),
        .flush_i     (redirect),
        .rd_idx_a_o  (rd_idx_a),
        .rd_idx_b_o  (rd_idx_b),
        .stall_o     (stall),
        .dx_ir_o     (dx_ir),
        .dx_pc_o     (dx_pc),
        .dx_a_o      (dx_a),
        .dx_b_o      (dx_b)
    );

    register_file u_regfile (
        .clock       (clock),
        .rst_n_i     (rst_n_i),
        .rd_idx_a_i  (rd_idx_a),
        .rd_idx_b_i  (rd_idx_b),
        .wr_idx_i    (wb_idx),
        .wr_data_i   (wb_data),
        .wr_en_i     (wb_en),
        .rd_data_a_o (rd_data_a),
        .rd_data_b_o (rd_data_b)
    );

    execute_stage u_execute (
        .clock             (clock),
        .rst_n_i           (rst_n_i),
        .dx_ir_i           (dx_ir),
        .dx_pc_i           (dx_pc),
        .dx_a_i            (dx_a),
        .dx_b_i            (dx_b),
        .wb_idx_i          (wb_idx),
        .wb_data_i         (wb_data),
        .wb_en_i           (wb_en),
        .redirect_o        (redirect),
        .redirect_target_o (redirect_target),
        .xm_ir_o           (xm_ir),
        .xm_result_o       (xm_result),
        .xm_b_o            (xm_b)
    );

    memory_stage u_memory (
        .clock        (clock),
        .rst_n_i      (rst_n_i),
        .xm_ir_i      (xm_ir),
        .xm_result_i  (xm_result),
        .xm_b_i       (xm_b),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_wren_o  (dmem_wren_o),
        .wb_idx_o     (wb_idx),
        .wb_data_o    (wb_data),
        .wb_en_o      (wb_en)
    );

endmodule

// File: verification/core_ref_model.svh
`ifndef CORE_REF_MODEL_SVH
`define CORE_REF_MODEL_SVH

// expected data-memory writes, oldest first
word_t exp_addr_q [$];
word_t exp_data_q [$];

function automatic word_t rtype_word(input alu_op_e fn, input int rd, input int rs,
                                     input int rt, input int shamt);
    word_t w;
    w = '0;
    w[`CORE_OP_MSB:`CORE_OP_LSB]       = OP_ALU;
    w[`CORE_RD_MSB:`CORE_RD_LSB]       = rd[4:0];
    w[`CORE_RS_MSB:`CORE_RS_LSB]       = rs[4:0];
    w[`CORE_RT_MSB:`CORE_RT_LSB]       = rt[4:0];
    w[`CORE_SHAMT_MSB:`CORE_SHAMT_LSB] = shamt[4:0];
    w[`CORE_ALUOP_MSB:`CORE_ALUOP_LSB] = fn;
    return w;
endfunction

// addi, lw, sw, bne, blt and jr share this layout
function automatic word_t itype_word(input opcode_e op, input int rd, input int rs,
                                     input int imm);
    word_t w;
    w = '0;
    w[`CORE_OP_MSB:`CORE_OP_LSB] = op;
    w[`CORE_RD_MSB:`CORE_RD_LSB] = rd[4:0];
    w[`CORE_RS_MSB:`CORE_RS_LSB] = rs[4:0];
    w[`CORE_IMM_WIDTH-1:0]       = imm[`CORE_IMM_WIDTH-1:0];
    return w;
endfunction

function automatic word_t jump_word(input opcode_e op, input int target);
    word_t w;
    w = '0;
    w[`CORE_OP_MSB:`CORE_OP_LSB] = op;
    w[`CORE_TARGET_WIDTH-1:0]    = target[`CORE_TARGET_WIDTH-1:0];
    return w;
endfunction

// one instruction per step from address 0 until the program parks on a self-jump
function automatic int run_reference(input int max_steps);
    word_t      regs [0:`CORE_REG_COUNT-1];
    word_t      mem  [0:MEM_WORDS-1];
    word_t      ir;
    word_t      pc;
    word_t      pc_next;
    word_t      rs_val;
    word_t      rt_val;
    word_t      rd_val;
    word_t      imm;
    word_t      addr;
    word_t      res;
    logic [4:0] op;
    logic [4:0] shamt;
    reg_idx_t   rd;
    logic       wr;
    logic       done;
    int         steps;
    int         i;
    for (i = 0; i < `CORE_REG_COUNT; i++) begin
        regs[i] = '0;
    end
    for (i = 0; i < MEM_WORDS; i++) begin
        mem[i] = '0;
    end
    exp_addr_q.delete();
    exp_data_q.delete();
    pc    = '0;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < max_steps) begin
        ir      = imem[pc[7:0]];
        op      = ir[`CORE_OP_MSB:`CORE_OP_LSB];
        rd      = ir[`CORE_RD_MSB:`CORE_RD_LSB];
        rs_val  = regs[ir[`CORE_RS_MSB:`CORE_RS_LSB]];
        rt_val  = regs[ir[`CORE_RT_MSB:`CORE_RT_LSB]];
        rd_val  = regs[rd];
        shamt   = ir[`CORE_SHAMT_MSB:`CORE_SHAMT_LSB];
        imm     = {{(`CORE_XLEN-`CORE_IMM_WIDTH){ir[`CORE_IMM_WIDTH-1]}},
                   ir[`CORE_IMM_WIDTH-1:0]};
        addr    = rs_val + imm;
        pc_next = pc + 1;
        wr      = 1'b0;
        res     = '0;
        case (op)
            OP_ALU: begin
                wr = 1'b1;
                case (ir[`CORE_ALUOP_MSB:`CORE_ALUOP_LSB])
                    ALU_ADD: res = rs_val + rt_val;
                    ALU_SUB: res = rs_val - rt_val;
                    ALU_AND: res = rs_val & rt_val;
                    ALU_OR:  res = rs_val | rt_val;
                    ALU_SLL: res = rs_val << shamt;
                    ALU_SRA: res = $signed(rs_val) >>> shamt;
                    default: res = '0;
                endcase
            end
            OP_ADDI: begin
                wr  = 1'b1;
                res = addr;
            end
            OP_LW: begin
                wr  = 1'b1;
                res = mem[addr[7:0]];
            end
            OP_SW: begin
                mem[addr[7:0]] = rd_val;
                exp_addr_q.push_back(addr);
                exp_data_q.push_back(rd_val);
            end
            OP_BNE:  if (rd_val != rs_val) pc_next = pc + 1 + imm;
            OP_BLT:  if ($signed(rd_val) < $signed(rs_val)) pc_next = pc + 1 + imm;
            OP_J:    pc_next = ir[`CORE_TARGET_WIDTH-1:0];
            OP_JAL: begin
                regs[`CORE_LINK_REG] = pc + 1;
                pc_next = ir[`CORE_TARGET_WIDTH-1:0];
            end
            OP_JR:   pc_next = rd_val;
            default: ;   // unused opcodes do nothing
        endcase
        if (wr) begin
            regs[rd] = res;
        end
        regs[0] = '0;
        done    = (pc_next == pc);
        pc      = pc_next;
        steps++;
    end
    return exp_addr_q.size();
endfunction

`endif

// File: verification/pipeline_core_tb.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module pipeline_core_tb import core_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 1;
    localparam int TAIL_CYCLES  = 20;
    localparam int MEM_WORDS    = 256;

    logic  clock;
    logic  rst_n;
    word_t imem_data;
    word_t dmem_rdata;
    word_t imem_addr;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_wren;

    word_t imem [0:MEM_WORDS-1];
    word_t dmem [0:MEM_WORDS-1];

    string cur_test;
    int    prog_len;
    int    exp_count;
    int    store_count;
    int    test_errors;
    int    total_errors;
    int    check_total;
    int    tests_run;
    int    seed;
    int    cycle_count = 0;
    int    cycle_limit = RESET_CYCLES;   // grows as each test is loaded

    `include "core_ref_model.svh"

    pipeline_core dut (
        .clock        (clock),
        .rst_n_i      (rst_n),
        .imem_data_i  (imem_data),
        .dmem_rdata_i (dmem_rdata),
        .imem_addr_o  (imem_addr),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_wren_o  (dmem_wren)
    );

    assign imem_data  = imem[imem_addr[7:0]];   // combinational reads
    assign dmem_rdata = dmem[dmem_addr[7:0]];

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        if (dmem_wren) begin
            dmem[dmem_addr[7:0]] <= dmem_wdata;
        end
    end

    // store monitor, compared in program order
    always @(negedge clock) begin
        if (rst_n && dmem_wren) begin
            if (store_count < exp_count) begin
                check_word({cur_test, " store addr"}, exp_addr_q[store_count], dmem_addr);
                check_word({cur_test, " store data"}, exp_data_q[store_count], dmem_wdata);
            end else begin
                $display("test %s: store of %h to address %h was not expected",
                         cur_test, dmem_wdata, dmem_addr);
                test_errors++;
            end
            store_count++;
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: test %s still running after %0d cycles", cur_test, cycle_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        check_total++;
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        check_total++;
        if (act != exp) begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic emit(input word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    // core held in reset while both memories are cleared
    task automatic start_program(input string name);
        int i;
        @(posedge clock);
        #DRIVE_DELAY;
        rst_n    = 1'b0;
        cur_test = name;
        prog_len = 0;
        for (i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
    endtask

    task automatic run_program();
        int end_pc;
        end_pc = prog_len;
        emit(jump_word(OP_J, end_pc));   // park here
        exp_count   = run_reference(4 * prog_len);
        store_count = 0;
        test_errors = 0;
        cycle_limit += RESET_CYCLES + 4 * prog_len + 40;
        repeat (RESET_CYCLES) @(posedge clock);
        if (dmem_wren !== 1'b0) begin
            $display("test %s: data-memory write enable is not low in reset", cur_test);
            test_errors++;
        end
        check_word({cur_test, " reset pc"}, '0, imem_addr);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        while (imem_addr != end_pc) begin
            @(negedge clock);
        end
        repeat (TAIL_CYCLES) @(posedge clock);
        check_count({cur_test, " store count"}, exp_count, store_count);
        $display("test %s: %0d stores, %0d errors", cur_test, store_count, test_errors);
        total_errors += test_errors;
        tests_run++;
    endtask

    task automatic test_alu_forwarding();
        int r;
        start_program("alu_forwarding");
        emit(itype_word(OP_ADDI, 1, 0, 5));
        emit(itype_word(OP_ADDI, 2, 0, -3));
        emit(rtype_word(ALU_ADD, 3, 1, 2, 0));   // r2 from mem, r1 from wb
        emit(rtype_word(ALU_SUB, 4, 3, 1, 0));
        emit(rtype_word(ALU_AND, 5, 4, 3, 0));
        emit(rtype_word(ALU_OR, 6, 5, 4, 0));
        emit(rtype_word(ALU_SLL, 7, 6, 0, 3));
        emit(rtype_word(ALU_SRA, 8, 2, 0, 1));
        emit(itype_word(OP_SW, 8, 0, 7));        // data straight from execute
        emit(itype_word(OP_ADDI, 9, 8, 1000));
        emit(itype_word(OP_SW, 9, 8, 20));       // address and data both forwarded
        for (r = 1; r <= 7; r++) begin
            emit(itype_word(OP_SW, r, 0, r - 1));
        end
        run_program();
    endtask

    task automatic test_load_use();
        start_program("load_use");
        emit(itype_word(OP_ADDI, 1, 0, 100));
        emit(itype_word(OP_SW, 1, 0, 10));
        emit(itype_word(OP_ADDI, 2, 0, 7));
        emit(itype_word(OP_SW, 2, 0, 11));
        emit(itype_word(OP_LW, 3, 0, 10));
        emit(rtype_word(ALU_ADD, 4, 3, 2, 0));   // one stall
        emit(itype_word(OP_LW, 5, 0, 11));
        emit(itype_word(OP_SW, 5, 0, 20));       // load data handed to the store
        emit(itype_word(OP_SW, 4, 0, 21));
        emit(itype_word(OP_LW, 6, 0, 20));
        emit(itype_word(OP_ADDI, 7, 6, 1));
        emit(itype_word(OP_LW, 8, 0, 21));
        emit(itype_word(OP_SW, 7, 8, 0));        // address from the load
        emit(itype_word(OP_LW, 9, 0, 10));
        emit(rtype_word(ALU_SUB, 10, 1, 9, 0));  // stall on rt
        emit(itype_word(OP_SW, 10, 0, 22));
        run_program();
    endtask

    task automatic test_branches();
        start_program("branches");
        emit(itype_word(OP_ADDI, 1, 0, -5));
        emit(itype_word(OP_ADDI, 2, 0, 3));
        emit(itype_word(OP_BLT, 1, 2, 2));       // -5 < 3, taken
        emit(itype_word(OP_SW, 1, 0, 30));       // squashed
        emit(itype_word(OP_SW, 2, 0, 31));       // squashed
        emit(itype_word(OP_BLT, 2, 1, 2));       // not taken
        emit(itype_word(OP_SW, 2, 0, 32));
        emit(itype_word(OP_BNE, 1, 1, 2));       // not taken
        emit(itype_word(OP_SW, 1, 0, 33));
        emit(itype_word(OP_BNE, 1, 2, 2));       // taken
        emit(itype_word(OP_SW, 1, 0, 34));
        emit(itype_word(OP_SW, 2, 0, 35));
        emit(itype_word(OP_ADDI, 3, 0, -1));
        emit(itype_word(OP_BLT, 1, 3, 2));       // both negative, taken
        emit(itype_word(OP_SW, 3, 0, 36));
        emit(itype_word(OP_SW, 3, 0, 37));
        emit(itype_word(OP_BLT, 3, 1, 2));
        emit(itype_word(OP_SW, 3, 0, 38));
        emit(itype_word(OP_LW, 4, 0, 32));
        emit(itype_word(OP_BNE, 4, 2, 2));       // stall, then equal
        emit(itype_word(OP_SW, 4, 0, 39));
        emit(itype_word(OP_BNE, 4, 0, 1));
        emit(itype_word(OP_SW, 0, 0, 40));
        emit(itype_word(OP_SW, 1, 0, 41));
        run_program();
    endtask

    task automatic test_jumps();
        start_program("jumps");
        emit(itype_word(OP_ADDI, 1, 0, 9));
        emit(jump_word(OP_JAL, 6));
        emit(itype_word(OP_SW, 1, 0, 40));       // return point
        emit(jump_word(OP_J, 10));
        emit(itype_word(OP_SW, 1, 0, 41));
        emit(itype_word(OP_SW, 1, 0, 42));
        emit(itype_word(OP_SW, 31, 0, 43));      // link value
        emit(itype_word(OP_ADDI, 2, 0, 20));
        emit(itype_word(OP_JR, 31, 0, 0));
        emit(itype_word(OP_SW, 1, 0, 44));
        emit(itype_word(OP_ADDI, 3, 0, 15));
        emit(itype_word(OP_JR, 3, 0, 0));        // target forwarded from memory stage
        emit(itype_word(OP_SW, 3, 0, 45));
        emit(itype_word(OP_SW, 3, 0, 46));
        emit(itype_word(OP_SW, 2, 0, 48));
        emit(itype_word(OP_SW, 2, 0, 47));
        run_program();
    endtask

    task automatic test_random();
        int i;
        int kind;
        int rd;
        int rs;
        int rt;
        start_program("random_alu");
        seed = 32'h326a;
        for (i = 0; i < 40; i++) begin
            kind = $unsigned($random(seed)) % 8;
            rd   = $unsigned($random(seed)) % 8;   // few registers, many hazards
            rs   = $unsigned($random(seed)) % 8;
            rt   = $unsigned($random(seed)) % 8;
            if (kind >= 6) begin
                emit(itype_word(OP_ADDI, rd, rs, $random(seed)));
            end else begin
                emit(rtype_word(alu_op_e'(kind), rd, rs, rt, $unsigned($random(seed)) % 32));
            end
        end
        for (i = 0; i < `CORE_REG_COUNT; i++) begin
            emit(itype_word(OP_SW, i, 0, 64 + i));
        end
        run_program();
    endtask

    initial begin
        rst_n        = 1'b0;
        cur_test     = "none";
        prog_len     = 0;
        exp_count    = 0;
        store_count  = 0;
        test_errors  = 0;
        total_errors = 0;
        check_total  = 0;
        tests_run    = 0;
        seed         = 32'h326a;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
        test_alu_forwarding();
        test_load_use();
        test_branches();
        test_jumps();
        test_random();
        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, check_total, total_errors);
        if (total_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: pipeline_core.f
+incdir+design
+incdir+verification
design/core_pkg.sv
design/fetch_stage.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/pipeline_core.sv
verification/pipeline_core_tb.sv
